// File: common/sdu_consts.svh
`ifndef SDU_CONSTS_SVH
`define SDU_CONSTS_SVH

// clock cycles per UART bit
// kept small so a frame stays short in simulation
`define SDU_CLKS_PER_BIT 16

// receive FIFO between uart_rx and the command processor
`define SDU_FIFO_DEPTH 8
`define SDU_FIFO_AW 3

// line feed closes every hex reply
`define SDU_ASCII_LF 8'h0A

// single byte replies
`define SDU_ASCII_ACK 8'h4B
`define SDU_ASCII_HALT 8'h48
`define SDU_ASCII_ERR 8'h3F

`endif

// File: common/sdu_pkg.sv
package sdu_pkg;

    // one received character, framing error flagged alongside
    typedef struct packed {
        logic [7:0] data;
        logic       frame_err;
    } rx_byte_t;

    // what the CPU exposes to the debug unit
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] npc;
        logic        pc_chk;
    } cpu_probe_t;

    // shared address bus for register file, data and instruction memory
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] din;
        logic        we_dm;
    } mem_req_t;

    // read ports, all addressed by mem_req_t.addr
    typedef struct packed {
        logic [31:0] dout_rf;
        logic [31:0] dout_dm;
        logic [31:0] dout_im;
    } rd_data_t;

    // command processor FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_OPND,
        ST_SETTLE,
        ST_REPLY,
        ST_RUN,
        ST_ERR
    } dcp_state_e;

endpackage

// File: uart/uart_rx.sv
`include "sdu_consts.svh"

module uart_rx (
    input  logic              clk,
    input  logic              reset,
    input  logic              rxd,
    output logic              rx_valid,
    output sdu_pkg::rx_byte_t rx_byte
);
    localparam int CPB = `SDU_CLKS_PER_BIT;
    localparam int CW = $clog2(CPB);
    localparam logic [CW-1:0] MID = CW'(CPB / 2 - 1);
    localparam logic [CW-1:0] LAST = CW'(CPB - 1);

    logic          rxd_meta;
    logic          rxd_sync;
    logic          rxd_prev;
    logic          start_edge;
    logic          active;
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_idx;
    logic [7:0]    rx_shift;

    assign start_edge = rxd_prev & ~rxd_sync;

    // two flops against metastability, a third for the edge
    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // bit_idx 0 is the start bit, 1..8 data, 9 the stop bit
    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!active) begin
                if (start_edge) begin
                    active  <= 1'b1;
                    clk_cnt <= '0;
                    bit_idx <= '0;
                end
            end else begin
                clk_cnt <= (clk_cnt == LAST) ? '0 : clk_cnt + 1'b1;
                if (clk_cnt == LAST) begin
                    bit_idx <= bit_idx + 4'd1;
                end
                // sample in the middle of each bit
                if (clk_cnt == MID) begin
                    if (bit_idx == 4'd0) begin
                        // glitch, line back high already
                        if (rxd_sync) begin
                            active <= 1'b0;
                        end
                    end else if (bit_idx == 4'd9) begin
                        active            <= 1'b0;
                        rx_valid          <= 1'b1;
                        rx_byte.data      <= rx_shift;
                        rx_byte.frame_err <= ~rxd_sync;
                    end else begin
                        // lsb arrives first
                        rx_shift <= {rxd_sync, rx_shift[7:1]};
                    end
                end
            end
        end
    end

endmodule

// File: uart/uart_tx.sv
`include "sdu_consts.svh"

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       txd,
    output logic       tx_busy
);
    localparam int CPB = `SDU_CLKS_PER_BIT;
    localparam int CW = $clog2(CPB);
    localparam logic [CW-1:0] LAST = CW'(CPB - 1);

    logic [9:0]    tx_shift;
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_cnt;

    // line idles high, the shift register holds ones when idle
    assign txd = tx_shift[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_shift <= '1;
            tx_busy  <= 1'b0;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
        end else begin
            if (!tx_busy) begin
                if (tx_start) begin
                    // stop, data lsb first, start
                    tx_shift <= {1'b1, tx_data, 1'b0};
                    tx_busy  <= 1'b1;
                    clk_cnt  <= '0;
                    bit_cnt  <= '0;
                end
            end else begin
                if (clk_cnt == LAST) begin
                    clk_cnt  <= '0;
                    tx_shift <= {1'b1, tx_shift[9:1]};
                    if (bit_cnt == 4'd9) begin
                        // stop bit done
                        tx_busy <= 1'b0;
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end else begin
                    clk_cnt <= clk_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: src/rx_fifo.sv
`include "sdu_consts.svh"

module rx_fifo (
    input  logic              clk,
    input  logic              reset,
    input  logic              push,
    input  sdu_pkg::rx_byte_t push_byte,
    input  logic              pop,
    output sdu_pkg::rx_byte_t fifo_head,
    output logic              fifo_empty,
    output logic              rx_overflow
);
    import sdu_pkg::*;

    localparam int AW = `SDU_FIFO_AW;
    localparam int DEPTH = `SDU_FIFO_DEPTH;

    rx_byte_t      buf_mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full       = (count == (AW + 1)'(DEPTH));
    assign fifo_empty = (count == '0);
    assign do_push    = push & ~full;
    assign do_pop     = pop & ~fifo_empty;
    assign fifo_head  = buf_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            buf_mem[wr_ptr] <= push_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            rx_overflow <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr + AW'(do_push);
            rd_ptr <= rd_ptr + AW'(do_pop);
            count  <= count + (AW + 1)'(do_push) - (AW + 1)'(do_pop);
            // sticky until reset
            if (push && full) begin
                rx_overflow <= 1'b1;
            end
        end
    end

endmodule

// File: dcp/debug_cmd_proc.sv
`include "sdu_consts.svh"

module debug_cmd_proc (
    input  logic                clk,
    input  logic                reset,
    input  sdu_pkg::rx_byte_t   fifo_head,
    input  logic                fifo_empty,
    output logic                pop,
    output logic [7:0]          tx_data,
    output logic                tx_start,
    input  logic                tx_busy,
    input  sdu_pkg::cpu_probe_t probe,
    input  sdu_pkg::rd_data_t   rd,
    output sdu_pkg::mem_req_t   mem,
    output logic                cpu_step
);
    import sdu_pkg::*;

    dcp_state_e  state;
    logic [7:0]  cmd;
    logic [4:0]  digits_left;
    logic [63:0] opnd;
    logic [63:0] opnd_nxt;
    logic [31:0] bp;
    logic [31:0] reply;
    logic [3:0]  reply_left;
    logic [7:0]  last_byte;
    logic [7:0]  next_byte;
    logic        settle_cnt;
    logic [31:0] mem_addr;
    logic [31:0] mem_din;
    logic        we_dm;
    logic        head_hex;
    logic        head_space;
    logic [3:0]  head_nib;

    function automatic logic [7:0] nib_to_ascii(input logic [3:0] nib);
        return (nib < 4'd10) ? 8'h30 + {4'h0, nib} : 8'h37 + {4'h0, nib};
    endfunction

    // ascii hex to nibble, uppercase only
    always_comb begin
        head_hex = !fifo_head.frame_err;
        head_nib = 4'h0;
        if (fifo_head.data >= "0" && fifo_head.data <= "9") begin
            head_nib = fifo_head.data[3:0];
        end else if (fifo_head.data >= "A" && fifo_head.data <= "F") begin
            head_nib = fifo_head.data[3:0] + 4'd9;
        end else begin
            head_hex = 1'b0;
        end
    end

    // separators are skipped between and inside operands
    assign head_space = !fifo_head.frame_err &&
                        (fifo_head.data == " " || fifo_head.data == 8'h0D ||
                         fifo_head.data == `SDU_ASCII_LF);

    assign opnd_nxt  = {opnd[59:0], head_nib};
    assign next_byte = (reply_left == 4'd1) ? last_byte : nib_to_ascii(reply[31:28]);
    assign pop       = !fifo_empty && (state == ST_IDLE || state == ST_OPND);
    assign mem       = '{addr: mem_addr, din: mem_din, we_dm: we_dm};

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            bp          <= '1;
            cpu_step    <= 1'b0;
            we_dm       <= 1'b0;
            tx_start    <= 1'b0;
            reply_left  <= '0;
            digits_left <= '0;
            settle_cnt  <= 1'b0;
        end else begin
            cpu_step <= 1'b0;
            we_dm    <= 1'b0;
            tx_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (!fifo_empty) begin
                        cmd  <= fifo_head.data;
                        opnd <= '0;
                        if (fifo_head.frame_err) begin
                            state <= ST_ERR;
                        end else begin
                            case (fifo_head.data)
                                "S": cpu_step <= 1'b1;
                                "G": begin
                                    cpu_step <= 1'b1;
                                    state    <= ST_RUN;
                                end
                                "P": begin
                                    reply      <= probe.pc;
                                    last_byte  <= `SDU_ASCII_LF;
                                    reply_left <= 4'd9;
                                    state      <= ST_REPLY;
                                end
                                "B", "D", "I": begin
                                    digits_left <= 5'd8;
                                    state       <= ST_OPND;
                                end
                                "R": begin
                                    digits_left <= 5'd2;
                                    state       <= ST_OPND;
                                end
                                "W": begin
                                    digits_left <= 5'd16;
                                    state       <= ST_OPND;
                                end
                                " ", 8'h0D, `SDU_ASCII_LF: ;
                                default: state <= ST_ERR;
                            endcase
                        end
                    end
                end
                ST_OPND: begin
                    if (!fifo_empty && !head_space) begin
                        if (!head_hex) begin
                            state <= ST_ERR;
                        end else begin
                            opnd        <= opnd_nxt;
                            digits_left <= digits_left - 5'd1;
                            if (digits_left == 5'd1) begin
                                case (cmd)
                                    "B": begin
                                        bp         <= opnd_nxt[31:0];
                                        last_byte  <= `SDU_ASCII_ACK;
                                        reply_left <= 4'd1;
                                        state      <= ST_REPLY;
                                    end
                                    "W": begin
                                        // address first, data second
                                        mem_addr   <= opnd_nxt[63:32];
                                        mem_din    <= opnd_nxt[31:0];
                                        we_dm      <= 1'b1;
                                        last_byte  <= `SDU_ASCII_ACK;
                                        reply_left <= 4'd1;
                                        state      <= ST_REPLY;
                                    end
                                    "R": begin
                                        mem_addr   <= {27'd0, opnd_nxt[4:0]};
                                        settle_cnt <= 1'b0;
                                        state      <= ST_SETTLE;
                                    end
                                    default: begin
                                        mem_addr   <= opnd_nxt[31:0];
                                        settle_cnt <= 1'b0;
                                        state      <= ST_SETTLE;
                                    end
                                endcase
                            end
                        end
                    end
                end
                ST_SETTLE: begin
                    // one cycle for the memories to follow addr
                    settle_cnt <= 1'b1;
                    if (settle_cnt) begin
                        case (cmd)
                            "R": reply <= rd.dout_rf;
                            "I": reply <= rd.dout_im;
                            default: reply <= rd.dout_dm;
                        endcase
                        last_byte  <= `SDU_ASCII_LF;
                        reply_left <= 4'd9;
                        state      <= ST_REPLY;
                    end
                end
                ST_REPLY: begin
                    // tx_busy rises one cycle late, so skip the cycle after a start
                    if (!tx_busy && !tx_start) begin
                        if (reply_left != 4'd0) begin
                            tx_start   <= 1'b1;
                            tx_data    <= next_byte;
                            reply      <= {reply[27:0], 4'h0};
                            reply_left <= reply_left - 4'd1;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_RUN: begin
                    // the step in flight lands pc on the breakpoint
                    if (probe.pc_chk && probe.npc == bp) begin
                        last_byte  <= `SDU_ASCII_HALT;
                        reply_left <= 4'd1;
                        state      <= ST_REPLY;
                    end else begin
                        cpu_step <= 1'b1;
                    end
                end
                ST_ERR: begin
                    last_byte  <= `SDU_ASCII_ERR;
                    reply_left <= 4'd1;
                    state      <= ST_REPLY;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: src/sdu.sv
module sdu (
    input  logic                clk,
    input  logic                reset,
    input  logic                rxd,
    output logic                txd,
    input  sdu_pkg::cpu_probe_t probe,
    input  sdu_pkg::rd_data_t   rd,
    output sdu_pkg::mem_req_t   mem,
    output logic                cpu_step,
    output logic                rx_overflow
);
    import sdu_pkg::*;

    logic       rx_valid;
    rx_byte_t   rx_byte;
    rx_byte_t   fifo_head;
    logic       fifo_empty;
    logic       pop;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    uart_rx i_rx (
        .clk      (clk),
        .reset    (reset),
        .rxd      (rxd),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    // buffers host bytes while a reply is on the line
    rx_fifo i_fifo (
        .clk         (clk),
        .reset       (reset),
        .push        (rx_valid),
        .push_byte   (rx_byte),
        .pop         (pop),
        .fifo_head   (fifo_head),
        .fifo_empty  (fifo_empty),
        .rx_overflow (rx_overflow)
    );

    debug_cmd_proc i_cmd (
        .clk        (clk),
        .reset      (reset),
        .fifo_head  (fifo_head),
        .fifo_empty (fifo_empty),
        .pop        (pop),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .tx_busy    (tx_busy),
        .probe      (probe),
        .rd         (rd),
        .mem        (mem),
        .cpu_step   (cpu_step)
    );

    uart_tx i_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .txd      (txd),
        .tx_busy  (tx_busy)
    );

endmodule

// File: tb/sdu_checker.sv
`include "sdu_consts.svh"

module sdu_checker (
    input logic                clk,
    input logic                reset,
    input logic                txd,
    input logic                tx_start,
    input logic                tx_busy,
    input logic                rx_valid,
    input logic                rx_overflow,
    input logic                cpu_step,
    input sdu_pkg::cpu_probe_t probe,
    input sdu_pkg::mem_req_t   mem,
    input logic [31:0]         bp,
    input logic                fifo_full
);
    timeunit 1ns;
    timeprecision 100ps;
    import sdu_pkg::*;

    localparam int CPB = `SDU_CLKS_PER_BIT;

    int fail_count = 0;

    // outputs settle to idle one edge into reset
    idle_in_reset: assert property (@(posedge clk)
        reset |=> txd && !cpu_step && !mem.we_dm && !tx_start && !rx_overflow)
        else begin
            $error("outputs not idle during reset");
            fail_count++;
        end

    start_bit_width: assert property (@(posedge clk) disable iff (reset)
        tx_start && !tx_busy |=> !txd [*CPB])
        else begin
            $error("start bit on txd shorter than one bit time");
            fail_count++;
        end

    we_dm_one_cycle: assert property (@(posedge clk) disable iff (reset)
        mem.we_dm |=> !mem.we_dm)
        else begin
            $error("we_dm held longer than one cycle");
            fail_count++;
        end

    // pc has landed on the breakpoint
    step_stops_at_bp: assert property (@(posedge clk) disable iff (reset)
        probe.pc_chk && probe.pc == bp |=> !cpu_step)
        else begin
            $error("cpu_step still high after breakpoint match");
            fail_count++;
        end

    full_write_flagged: assert property (@(posedge clk) disable iff (reset)
        rx_valid && fifo_full |=> rx_overflow)
        else begin
            $error("write into full FIFO without rx_overflow");
            fail_count++;
        end

endmodule

bind sdu sdu_checker i_chk (
    .clk         (clk),
    .reset       (reset),
    .txd         (txd),
    .tx_start    (tx_start),
    .tx_busy     (tx_busy),
    .rx_valid    (rx_valid),
    .rx_overflow (rx_overflow),
    .cpu_step    (cpu_step),
    .probe       (probe),
    .mem         (mem),
    .bp          (i_cmd.bp),
    .fifo_full   (i_fifo.full)
);

// File: tb/sdu_tb.sv
`include "sdu_consts.svh"

module sdu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import sdu_pkg::*;

    localparam int CPB = `SDU_CLKS_PER_BIT;
    localparam int BYTE_CYCLES = 10 * CPB;
    // all tests together move well under 400 bytes
    localparam int WATCHDOG_CYCLES = 400 * BYTE_CYCLES;

    logic        clk;
    logic        reset;
    logic        rxd;
    logic        txd;
    cpu_probe_t  probe;
    rd_data_t    rd;
    mem_req_t    mem;
    logic        cpu_step;
    logic        rx_overflow;

    logic [31:0] cpu_pc;
    logic        cpu_chk;
    logic [31:0] dm_store [logic [31:0]];
    logic [31:0] w_addr;
    logic [31:0] w_data;
    int          we_pulses;
    int          errors;

    sdu i_dut (
        .clk         (clk),
        .reset       (reset),
        .rxd         (rxd),
        .txd         (txd),
        .probe       (probe),
        .rd          (rd),
        .mem         (mem),
        .cpu_step    (cpu_step),
        .rx_overflow (rx_overflow)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, got);
            errors++;
        end
    endtask

    // hex digits on the serial line are upper case only
    function automatic string to_upper(input string s);
        return s.toupper();
    endfunction

    // cpu model, one step per cycle of cpu_step
    always @(posedge clk) begin
        if (reset) begin
            cpu_pc  <= '0;
            cpu_chk <= 1'b0;
        end else begin
            cpu_chk <= cpu_step;
            if (cpu_step) begin
                cpu_pc <= cpu_pc + 32'd4;
            end
        end
    end

    // memories and probe, driven on the falling edge
    always @(negedge clk) begin
        if (!reset && mem.we_dm) begin
            we_pulses++;
            check_value("mem.addr", mem.addr, w_addr);
            check_value("mem.din", mem.din, w_data);
            dm_store[mem.addr] = mem.din;
        end
        probe.pc     = cpu_pc;
        probe.npc    = cpu_pc + 32'd4;
        probe.pc_chk = cpu_chk;
        rd.dout_rf   = {27'd0, mem.addr[4:0]} * 32'h0101_0101;
        rd.dout_im   = mem.addr + 32'h0000_1000;
        rd.dout_dm   = dm_store.exists(mem.addr) ? dm_store[mem.addr] : ~mem.addr;
    end

    task automatic send_byte(input logic [7:0] b);
        int i;
        rxd = 1'b0;
        repeat (CPB) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rxd = b[i];
            repeat (CPB) @(negedge clk);
        end
        rxd = 1'b1;
        repeat (CPB) @(negedge clk);
    endtask

    task automatic send_text(input string s);
        int i;
        for (i = 0; i < s.len(); i++) begin
            send_byte(s[i]);
        end
    endtask

    task automatic recv_byte(output logic [7:0] b);
        int i;
        @(negedge clk);
        while (txd !== 1'b0) @(negedge clk);
        // middle of the start bit
        repeat (CPB / 2) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            repeat (CPB) @(negedge clk);
            b[i] = txd;
        end
        repeat (CPB) @(negedge clk);
        if (txd !== 1'b1) begin
            $display("stop bit on txd was low at %0d ns", $time);
            errors++;
        end
    endtask

    task automatic expect_reply(input string s);
        int         i;
        logic [7:0] got;
        for (i = 0; i < s.len(); i++) begin
            recv_byte(got);
            check_value("txd_byte", {24'd0, got}, {24'd0, s[i]});
        end
    endtask

    task automatic run_cmd(input string cmd, input string reply);
        fork
            send_text(cmd);
            expect_reply(reply);
        join
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int          seed;
        int          round;
        logic [31:0] addr;
        logic [7:0]  idx;
        logic [31:0] exp_pc;
        logic [31:0] bp;
        string       burst;

        seed      = 32'he81ccf11;
        clk       = 1'b0;
        reset     = 1'b1;
        rxd       = 1'b1;
        probe     = '0;
        rd        = '0;
        errors    = 0;
        we_pulses = 0;
        w_addr    = '0;
        w_data    = '0;
        exp_pc    = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("txd", {31'd0, txd}, 32'd1);
        check_value("cpu_step", {31'd0, cpu_step}, 32'd0);
        check_value("mem.we_dm", {31'd0, mem.we_dm}, 32'd0);
        check_value("rx_overflow", {31'd0, rx_overflow}, 32'd0);

        // reads with random operands
        for (round = 0; round < 2; round++) begin
            idx = 8'($random(seed));
            run_cmd(to_upper($sformatf("R %02X", idx)),
                    to_upper($sformatf("%08X\n", {27'd0, idx[4:0]} * 32'h0101_0101)));
            addr = $random(seed);
            run_cmd(to_upper($sformatf("D %08X", addr)),
                    to_upper($sformatf("%08X\n", ~addr)));
            addr = $random(seed);
            run_cmd(to_upper($sformatf("I %08X", addr)),
                    to_upper($sformatf("%08X\n", addr + 32'h0000_1000)));
            run_cmd("P", to_upper($sformatf("%08X\n", exp_pc)));
        end

        // write then read back
        w_addr    = $random(seed);
        w_data    = $random(seed);
        we_pulses = 0;
        run_cmd(to_upper($sformatf("W %08X %08X", w_addr, w_data)), "K");
        assert (we_pulses == 1) else begin
            $display("W gave %0d we_dm pulses instead of one", we_pulses);
            errors++;
        end
        run_cmd(to_upper($sformatf("D %08X", w_addr)),
                to_upper($sformatf("%08X\n", w_data)));

        // single step, then run to breakpoint
        send_text("S");
        exp_pc = exp_pc + 32'd4;
        run_cmd("P", to_upper($sformatf("%08X\n", exp_pc)));
        bp = exp_pc + 32'd40;
        run_cmd(to_upper($sformatf("B %08X", bp)), "K");
        run_cmd("G", "H");
        exp_pc = bp;
        run_cmd("P", to_upper($sformatf("%08X\n", exp_pc)));

        run_cmd("X", "?");
        run_cmd("W 12Z", "?");

        // each queued P keeps the FIFO blocked behind another reply
        burst = "";
        repeat (20) burst = {burst, "P"};
        addr = $random(seed);
        fork
            begin
                send_text(to_upper($sformatf("D %08X", addr)));
                send_text(burst);
            end
            expect_reply(to_upper($sformatf("%08X\n", ~addr)));
        join
        assert (rx_overflow === 1'b1) else begin
            $display("rx_overflow did not rise after twenty bytes during a reply");
            errors++;
        end

        $display("errors: %0d value checks, %0d assertions", errors, i_dut.i_chk.fail_count);
        if (errors == 0 && i_dut.i_chk.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sdu.f
+incdir+common
common/sdu_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
src/rx_fifo.sv
dcp/debug_cmd_proc.sv
src/sdu.sv
tb/sdu_checker.sv
tb/sdu_tb.sv
